// ==== verilog/eth_stream_pkg.sv ====
// Stream widths and the first-beat view shared by the packet datapath.
// Import into any module or interface that carries the 64-bit MAC stream.
`default_nettype none

package eth_stream_pkg;

  localparam int ETH_DW = 64;
  // Valid bytes in the last beat, 0 means all eight
  localparam int ETH_UW = 4;
  localparam int CPU_KW = 8;

  // Simplified link header on the first beat of a frame
  typedef struct packed {
    logic [47:0] dst_mac;
    logic [15:0] ethertype;
  } eth_hdr_t;

  // Header view for routing, byte view for the CPU swap
  typedef union packed {
    eth_hdr_t                      hdr;
    logic [ETH_DW/8-1:0][7:0]      bytes;
  } eth_beat_u;

endpackage

`default_nettype wire

// ==== verilog/net_regs_pkg.sv ====
// Register port widths, register map and reset values of the network port.
`default_nettype none

package net_regs_pkg;

  localparam int REG_AW = 14;
  localparam int REG_DW = 32;

  // Register map
  localparam logic [REG_AW-1:0] REG_CTRL        = 14'h00;
  localparam logic [REG_AW-1:0] REG_VITA_TYPE   = 14'h04;
  localparam logic [REG_AW-1:0] REG_RX_CPU_CNT  = 14'h08;
  localparam logic [REG_AW-1:0] REG_RX_VITA_CNT = 14'h0C;
  localparam logic [REG_AW-1:0] REG_TX_CNT      = 14'h10;

  localparam logic        ROUTE_EN_RST  = 1'b1;
  localparam logic [15:0] VITA_TYPE_RST = 16'h88B5;

  // Activity LED hold time in bus_clk cycles
  localparam int ACT_STRETCH = 16;

endpackage

`default_nettype wire

// ==== verilog/axis_if.sv ====
// 64-bit frame stream with tuser byte count and a tvalid/tready handshake.
// A beat moves on a clock edge with tvalid and tready both high.
`timescale 1ns/1ps
`default_nettype none

interface axis_if import eth_stream_pkg::*; ();

  eth_beat_u         tdata;
  logic [ETH_UW-1:0] tuser;
  logic              tlast;
  logic              tvalid;
  logic              tready;

  modport source (output tdata, tuser, tlast, tvalid, input tready);
  modport sink   (input tdata, tuser, tlast, tvalid, output tready);

endinterface

`default_nettype wire

// ==== verilog/net_ctrl.sv ====
// Register block of the network port: routing setup, frame counters and the
// activity LED. Reads answer one cycle after the request, writes land next cycle.
`timescale 1ns/1ps
`default_nettype none

module net_ctrl import net_regs_pkg::*; (
  input  logic              bus_clk,
  input  logic              rst_n,
  input  logic              reg_wr_req,
  input  logic [REG_AW-1:0] reg_wr_addr,
  input  logic [REG_DW-1:0] reg_wr_data,
  input  logic              reg_rd_req,
  input  logic [REG_AW-1:0] reg_rd_addr,
  output logic              reg_rd_resp,
  output logic [REG_DW-1:0] reg_rd_data,
  input  logic              rx_cpu_pkt,
  input  logic              rx_vita_pkt,
  input  logic              tx_pkt,
  input  logic              rx_beat,
  input  logic              tx_beat,
  output logic              vita_route_en,
  output logic [15:0]       vita_type,
  output logic              activity_led
);

  logic [2:0]              cnt_evt;
  logic [2:0]              cnt_clr;
  logic [REG_DW-1:0]       pkt_cnt [3];
  logic [$clog2(ACT_STRETCH)-1:0] act_cnt;

  ////////////////////
  // Config registers
  always_ff @(posedge bus_clk) begin
    if (!rst_n) begin
      vita_route_en <= ROUTE_EN_RST;
      vita_type     <= VITA_TYPE_RST;
    end else if (reg_wr_req) begin
      case (reg_wr_addr)
        REG_CTRL:      vita_route_en <= reg_wr_data[0];
        REG_VITA_TYPE: vita_type     <= reg_wr_data[15:0];
        default: ;
      endcase
    end
  end

  ////////////////////
  // Frame counters, index 0 rx cpu, 1 rx vita, 2 tx
  assign cnt_evt = {tx_pkt, rx_vita_pkt, rx_cpu_pkt};
  assign cnt_clr = {reg_wr_req && (reg_wr_addr == REG_TX_CNT),
                    reg_wr_req && (reg_wr_addr == REG_RX_VITA_CNT),
                    reg_wr_req && (reg_wr_addr == REG_RX_CPU_CNT)};

  always_ff @(posedge bus_clk) begin
    for (int i = 0; i < 3; i++) begin
      // Clear by write wins over a same-cycle event
      if (!rst_n || cnt_clr[i]) pkt_cnt[i] <= '0;
      else if (cnt_evt[i])      pkt_cnt[i] <= pkt_cnt[i] + 1'b1;
    end
  end

  ////////////////////
  // Read side
  always_ff @(posedge bus_clk) begin
    if (!rst_n) reg_rd_resp <= 1'b0;
    else        reg_rd_resp <= reg_rd_req;
  end

  always_ff @(posedge bus_clk) begin
    if (reg_rd_req) begin
      case (reg_rd_addr)
        REG_CTRL:        reg_rd_data <= {{(REG_DW-1){1'b0}}, vita_route_en};
        REG_VITA_TYPE:   reg_rd_data <= {{(REG_DW-16){1'b0}}, vita_type};
        REG_RX_CPU_CNT:  reg_rd_data <= pkt_cnt[0];
        REG_RX_VITA_CNT: reg_rd_data <= pkt_cnt[1];
        REG_TX_CNT:      reg_rd_data <= pkt_cnt[2];
        default:         reg_rd_data <= '0;
      endcase
    end
  end

  ////////////////////
  // Activity LED, reloaded on every beat in either direction
  always_ff @(posedge bus_clk) begin
    if (!rst_n)                 act_cnt <= '0;
    else if (rx_beat | tx_beat) act_cnt <= $bits(act_cnt)'(ACT_STRETCH - 1);
    else if (act_cnt != '0)     act_cnt <= act_cnt - 1'b1;
  end

  assign activity_led = (act_cnt != '0);

  // Request strobes are single-cycle pulses
  a_rd_req_pulse: assert property (@(posedge bus_clk) disable iff (!rst_n)
    reg_rd_req |=> !reg_rd_req);

  a_wr_req_pulse: assert property (@(posedge bus_clk) disable iff (!rst_n)
    reg_wr_req |=> !reg_wr_req);

endmodule

`default_nettype wire

// ==== verilog/eth_rx_router.sv ====
// Steers each received frame to the VITA engine or the CPU.
// Route is picked on the first beat from the frame type and held to tlast.
`timescale 1ns/1ps
`default_nettype none

module eth_rx_router import eth_stream_pkg::*; (
  input  logic        bus_clk,
  input  logic        rst_n,
  input  logic        vita_route_en,
  input  logic [15:0] vita_type,
  axis_if.sink        eth_rx,
  axis_if.source      to_vita,
  axis_if.source      to_cpu,
  output logic        rx_vita_pkt,
  output logic        rx_cpu_pkt,
  output logic        rx_beat
);

  logic in_frame;
  logic route_vita_q;
  logic hdr_is_vita;
  logic sel_vita;
  logic beat;

  // Header match only counts on the first beat
  assign hdr_is_vita = vita_route_en && (eth_rx.tdata.hdr.ethertype == vita_type);
  assign sel_vita    = in_frame ? route_vita_q : hdr_is_vita;

  assign beat = eth_rx.tvalid && eth_rx.tready;

  always_ff @(posedge bus_clk) begin
    if (!rst_n) begin
      in_frame     <= 1'b0;
      route_vita_q <= 1'b0;
    end else if (beat) begin
      in_frame     <= !eth_rx.tlast;
      route_vita_q <= sel_vita;
    end
  end

  ////////////////////
  // Fan out, payload goes to both and tvalid picks the target
  assign to_vita.tdata  = eth_rx.tdata;
  assign to_vita.tuser  = eth_rx.tuser;
  assign to_vita.tlast  = eth_rx.tlast;
  assign to_vita.tvalid = eth_rx.tvalid && sel_vita;

  assign to_cpu.tdata  = eth_rx.tdata;
  assign to_cpu.tuser  = eth_rx.tuser;
  assign to_cpu.tlast  = eth_rx.tlast;
  assign to_cpu.tvalid = eth_rx.tvalid && !sel_vita;

  assign eth_rx.tready = sel_vita ? to_vita.tready : to_cpu.tready;

  // Event strobes for the counters and LED
  assign rx_beat     = beat;
  assign rx_vita_pkt = beat && eth_rx.tlast && sel_vita;
  assign rx_cpu_pkt  = beat && eth_rx.tlast && !sel_vita;

  // A stalled header beat must not change, or the route could flip
  a_rx_hold: assert property (@(posedge bus_clk) disable iff (!rst_n)
    (eth_rx.tvalid && !eth_rx.tready) |=>
      (eth_rx.tvalid && $stable(eth_rx.tdata) && $stable(eth_rx.tlast)));

endmodule

`default_nettype wire

// ==== verilog/eth_tx_arbiter.sv ====
// Merges the VITA and CPU transmit streams onto the MAC, one whole frame at
// a time. Ties go to the side that did not win the previous frame.
`timescale 1ns/1ps
`default_nettype none

module eth_tx_arbiter import eth_stream_pkg::*; (
  input  logic   bus_clk,
  input  logic   rst_n,
  axis_if.sink   from_vita,
  axis_if.sink   from_cpu,
  axis_if.source eth_tx,
  output logic   tx_pkt,
  output logic   tx_beat
);

  logic locked;
  // Grant of the current frame, or the last winner between frames
  logic grant_vita_q;
  logic pick_vita;
  logic sel_vita;
  logic beat;

  assign pick_vita = from_vita.tvalid && (!from_cpu.tvalid || !grant_vita_q);
  assign sel_vita  = locked ? grant_vita_q : pick_vita;

  assign beat = eth_tx.tvalid && eth_tx.tready;

  // Lock as soon as a beat is offered so a stalled beat stays put
  always_ff @(posedge bus_clk) begin
    if (!rst_n) begin
      locked       <= 1'b0;
      grant_vita_q <= 1'b0;
    end else if (eth_tx.tvalid) begin
      locked       <= !(eth_tx.tready && eth_tx.tlast);
      grant_vita_q <= sel_vita;
    end
  end

  ////////////////////
  // Output mux, VITA frames are always full beats
  assign eth_tx.tdata  = sel_vita ? from_vita.tdata  : from_cpu.tdata;
  assign eth_tx.tuser  = sel_vita ? '0               : from_cpu.tuser;
  assign eth_tx.tlast  = sel_vita ? from_vita.tlast  : from_cpu.tlast;
  assign eth_tx.tvalid = sel_vita ? from_vita.tvalid : from_cpu.tvalid;

  assign from_vita.tready = sel_vita && eth_tx.tready;
  assign from_cpu.tready  = !sel_vita && eth_tx.tready;

  assign tx_beat = beat;
  assign tx_pkt  = beat && eth_tx.tlast;

  // An offered beat on the MAC side stays put until it is taken
  a_tx_hold: assert property (@(posedge bus_clk) disable iff (!rst_n)
    (eth_tx.tvalid && !eth_tx.tready) |=>
      (eth_tx.tvalid && $stable(eth_tx.tdata) && $stable(eth_tx.tlast)));

endmodule

`default_nettype wire

// ==== verilog/cpu_stream_adapter.sv ====
// CPU side of the port: byte swap in both directions and the translation
// between the tuser byte count and the CPU tkeep mask. Purely combinational.
`timescale 1ns/1ps
`default_nettype none

module cpu_stream_adapter import eth_stream_pkg::*; (
  axis_if.sink              to_cpu,
  axis_if.source            from_cpu,
  output logic [ETH_DW-1:0] e2c_tdata,
  output logic [CPU_KW-1:0] e2c_tkeep,
  output logic              e2c_tlast,
  output logic              e2c_tvalid,
  input  logic              e2c_tready,
  input  logic [ETH_DW-1:0] c2e_tdata,
  input  logic [CPU_KW-1:0] c2e_tkeep,
  input  logic              c2e_tlast,
  input  logic              c2e_tvalid,
  output logic              c2e_tready
);

  function automatic eth_beat_u byte_swap(input eth_beat_u w);
    eth_beat_u r;
    for (int i = 0; i < ETH_DW/8; i++) begin
      r.bytes[i] = w.bytes[ETH_DW/8-1-i];
    end
    return r;
  endfunction

  ////////////////////
  // MAC to CPU
  assign e2c_tdata     = byte_swap(to_cpu.tdata);
  assign e2c_tlast     = to_cpu.tlast;
  assign e2c_tvalid    = to_cpu.tvalid;
  assign to_cpu.tready = e2c_tready;

  // Partial last beat keeps n lanes from lane 0
  always_comb begin
    e2c_tkeep = '1;
    if (to_cpu.tlast && (to_cpu.tuser != '0))
      e2c_tkeep = (CPU_KW'(1) << to_cpu.tuser) - CPU_KW'(1);
  end

  ////////////////////
  // CPU to MAC
  assign from_cpu.tdata  = byte_swap(c2e_tdata);
  assign from_cpu.tlast  = c2e_tlast;
  assign from_cpu.tvalid = c2e_tvalid;
  assign c2e_tready      = from_cpu.tready;

  // Only a contiguous mask from lane 0 maps to a count, anything else is full
  always_comb begin
    from_cpu.tuser = '0;
    if (c2e_tlast) begin
      for (int n = 1; n < CPU_KW; n++) begin
        if (c2e_tkeep == ((CPU_KW'(1) << n) - CPU_KW'(1)))
          from_cpu.tuser = ETH_UW'(n);
      end
    end
  end

endmodule

`default_nettype wire

// ==== verilog/net_if_top.sv ====
// Packet side of the network port on bus_clk. Connects the receive router,
// transmit merge, CPU adapter and register block to the plain top ports.
`timescale 1ns/1ps
`default_nettype none

module net_if_top import eth_stream_pkg::*; import net_regs_pkg::*; (
  input  logic              bus_clk,
  input  logic              rst_n,
  // Register port
  input  logic              reg_wr_req,
  input  logic [REG_AW-1:0] reg_wr_addr,
  input  logic [REG_DW-1:0] reg_wr_data,
  input  logic              reg_rd_req,
  input  logic [REG_AW-1:0] reg_rd_addr,
  output logic              reg_rd_resp,
  output logic [REG_DW-1:0] reg_rd_data,
  // MAC receive and transmit
  input  logic [ETH_DW-1:0] eth_rx_tdata,
  input  logic [ETH_UW-1:0] eth_rx_tuser,
  input  logic              eth_rx_tlast,
  input  logic              eth_rx_tvalid,
  output logic              eth_rx_tready,
  output logic [ETH_DW-1:0] eth_tx_tdata,
  output logic [ETH_UW-1:0] eth_tx_tuser,
  output logic              eth_tx_tlast,
  output logic              eth_tx_tvalid,
  input  logic              eth_tx_tready,
  // VITA engine
  output logic [ETH_DW-1:0] e2v_tdata,
  output logic              e2v_tlast,
  output logic              e2v_tvalid,
  input  logic              e2v_tready,
  input  logic [ETH_DW-1:0] v2e_tdata,
  input  logic              v2e_tlast,
  input  logic              v2e_tvalid,
  output logic              v2e_tready,
  // CPU
  output logic [ETH_DW-1:0] e2c_tdata,
  output logic [CPU_KW-1:0] e2c_tkeep,
  output logic              e2c_tlast,
  output logic              e2c_tvalid,
  input  logic              e2c_tready,
  input  logic [ETH_DW-1:0] c2e_tdata,
  input  logic [CPU_KW-1:0] c2e_tkeep,
  input  logic              c2e_tlast,
  input  logic              c2e_tvalid,
  output logic              c2e_tready,
  output logic              activity_led
);

  logic        rx_cpu_pkt;
  logic        rx_vita_pkt;
  logic        tx_pkt;
  logic        rx_beat;
  logic        tx_beat;
  logic        vita_route_en;
  logic [15:0] vita_type;

  axis_if rx_if ();
  axis_if e2v_if ();
  axis_if e2c_if ();
  axis_if v2e_if ();
  axis_if c2e_if ();
  axis_if tx_if ();

  ////////////////////
  // Plain ports to stream links
  assign rx_if.tdata   = eth_rx_tdata;
  assign rx_if.tuser   = eth_rx_tuser;
  assign rx_if.tlast   = eth_rx_tlast;
  assign rx_if.tvalid  = eth_rx_tvalid;
  assign eth_rx_tready = rx_if.tready;

  assign eth_tx_tdata  = tx_if.tdata;
  assign eth_tx_tuser  = tx_if.tuser;
  assign eth_tx_tlast  = tx_if.tlast;
  assign eth_tx_tvalid = tx_if.tvalid;
  assign tx_if.tready  = eth_tx_tready;

  // VITA side carries no byte count
  assign e2v_tdata     = e2v_if.tdata;
  assign e2v_tlast     = e2v_if.tlast;
  assign e2v_tvalid    = e2v_if.tvalid;
  assign e2v_if.tready = e2v_tready;

  assign v2e_if.tdata  = v2e_tdata;
  assign v2e_if.tlast  = v2e_tlast;
  assign v2e_if.tvalid = v2e_tvalid;
  assign v2e_tready    = v2e_if.tready;

  ////////////////////
  // Blocks
  net_ctrl u_ctrl (
    .bus_clk, .rst_n,
    .reg_wr_req, .reg_wr_addr, .reg_wr_data,
    .reg_rd_req, .reg_rd_addr, .reg_rd_resp, .reg_rd_data,
    .rx_cpu_pkt, .rx_vita_pkt, .tx_pkt, .rx_beat, .tx_beat,
    .vita_route_en, .vita_type, .activity_led
  );

  eth_rx_router u_router (
    .bus_clk, .rst_n, .vita_route_en, .vita_type,
    .eth_rx (rx_if), .to_vita (e2v_if), .to_cpu (e2c_if),
    .rx_vita_pkt, .rx_cpu_pkt, .rx_beat
  );

  eth_tx_arbiter u_arb (
    .bus_clk, .rst_n,
    .from_vita (v2e_if), .from_cpu (c2e_if), .eth_tx (tx_if),
    .tx_pkt, .tx_beat
  );

  cpu_stream_adapter u_cpu (
    .to_cpu (e2c_if), .from_cpu (c2e_if),
    .e2c_tdata, .e2c_tkeep, .e2c_tlast, .e2c_tvalid, .e2c_tready,
    .c2e_tdata, .c2e_tkeep, .c2e_tlast, .c2e_tvalid, .c2e_tready
  );

endmodule

`default_nettype wire

// ==== tests/net_if_tb.sv ====
// Directed testbench for the network port packet side.
// Drives the MAC, VITA, CPU and register ports and checks every output beat
// against expected queues built from the port's routing and conversion rules.
`timescale 1ns/1ps
`default_nettype none

module net_if_tb import eth_stream_pkg::*; import net_regs_pkg::*; ();

  localparam int TIMEOUT = 500;

  logic              bus_clk = 1'b0;
  logic              rst_n;
  logic              reg_wr_req;
  logic [REG_AW-1:0] reg_wr_addr;
  logic [REG_DW-1:0] reg_wr_data;
  logic              reg_rd_req;
  logic [REG_AW-1:0] reg_rd_addr;
  logic              reg_rd_resp;
  logic [REG_DW-1:0] reg_rd_data;
  logic [ETH_DW-1:0] eth_rx_tdata;
  logic [ETH_UW-1:0] eth_rx_tuser;
  logic              eth_rx_tlast;
  logic              eth_rx_tvalid;
  logic              eth_rx_tready;
  logic [ETH_DW-1:0] eth_tx_tdata;
  logic [ETH_UW-1:0] eth_tx_tuser;
  logic              eth_tx_tlast;
  logic              eth_tx_tvalid;
  logic              eth_tx_tready;
  logic [ETH_DW-1:0] e2v_tdata;
  logic              e2v_tlast;
  logic              e2v_tvalid;
  logic              e2v_tready;
  logic [ETH_DW-1:0] v2e_tdata;
  logic              v2e_tlast;
  logic              v2e_tvalid;
  logic              v2e_tready;
  logic [ETH_DW-1:0] e2c_tdata;
  logic [CPU_KW-1:0] e2c_tkeep;
  logic              e2c_tlast;
  logic              e2c_tvalid;
  logic              e2c_tready;
  logic [ETH_DW-1:0] c2e_tdata;
  logic [CPU_KW-1:0] c2e_tkeep;
  logic              c2e_tlast;
  logic              c2e_tvalid;
  logic              c2e_tready;
  logic              activity_led;

  int          errors = 0;
  int          n_rx_vita = 0;
  int          n_rx_cpu = 0;
  int          n_tx = 0;
  string       test_name = "reset";
  logic [31:0] lcg_state = 32'd64;
  logic [7:0]  cyc = '0;
  logic        stall_en = 1'b0;

  // Expected beats per output, consumed by the monitors
  eth_beat_u         exp_v_data[$];
  logic              exp_v_last[$];
  eth_beat_u         exp_c_data[$];
  logic [CPU_KW-1:0] exp_c_keep[$];
  logic              exp_c_last[$];
  eth_beat_u         exp_t_data[$];
  logic [ETH_UW-1:0] exp_t_user[$];
  logic              exp_t_last[$];

  net_if_top DUT (
    .bus_clk, .rst_n,
    .reg_wr_req, .reg_wr_addr, .reg_wr_data,
    .reg_rd_req, .reg_rd_addr, .reg_rd_resp, .reg_rd_data,
    .eth_rx_tdata, .eth_rx_tuser, .eth_rx_tlast, .eth_rx_tvalid, .eth_rx_tready,
    .eth_tx_tdata, .eth_tx_tuser, .eth_tx_tlast, .eth_tx_tvalid, .eth_tx_tready,
    .e2v_tdata, .e2v_tlast, .e2v_tvalid, .e2v_tready,
    .v2e_tdata, .v2e_tlast, .v2e_tvalid, .v2e_tready,
    .e2c_tdata, .e2c_tkeep, .e2c_tlast, .e2c_tvalid, .e2c_tready,
    .c2e_tdata, .c2e_tkeep, .c2e_tlast, .c2e_tvalid, .c2e_tready,
    .activity_led
  );

  always #10 bus_clk = ~bus_clk;

  // Sink ready patterns, each output stalls on its own phase
  always @(posedge bus_clk) begin
    cyc           <= cyc + 8'd1;
    e2v_tready    <= !(stall_en && cyc[1:0] == 2'd2);
    e2c_tready    <= !(stall_en && cyc[2:0] == 3'd5);
    eth_tx_tready <= !(stall_en && cyc[1:0] == 2'd1);
  end

  ////////////////////
  // Reference models

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  function automatic logic [ETH_DW-1:0] rand64();
    logic [31:0] hi;
    logic [31:0] lo;
    hi = lcg_next();
    lo = lcg_next();
    return {hi, lo};
  endfunction

  // Byte 0 of the input lands in the top byte of the output
  function automatic eth_beat_u swap_ref(input logic [ETH_DW-1:0] w);
    logic [ETH_DW-1:0] r;
    for (int i = 0; i < ETH_DW/8; i++) begin
      r[8*i +: 8] = w[ETH_DW-8-8*i +: 8];
    end
    return r;
  endfunction

  function automatic logic [CPU_KW-1:0] keep_ref(input logic last, input logic [ETH_UW-1:0] user);
    logic [CPU_KW-1:0] k;
    k = '1;
    if (last && user != 0) begin
      k = '0;
      for (int i = 0; i < int'(user); i++) begin
        k[i] = 1'b1;
      end
    end
    return k;
  endfunction

  // Count of ones from lane 0, valid only if nothing is set above them
  function automatic logic [ETH_UW-1:0] user_ref(input logic last, input logic [CPU_KW-1:0] keep);
    int n;
    n = 0;
    while (n < CPU_KW && keep[n]) begin
      n++;
    end
    if (last && n > 0 && n < CPU_KW && (keep >> n) == 0) return ETH_UW'(n);
    return '0;
  endfunction

  ////////////////////
  // Compare tasks

  task automatic check_beat(input string name, input eth_beat_u exp, input eth_beat_u act);
    if (act !== exp) begin
      errors++;
      $display("ERROR %s: expected %h, actual %h", name, exp, act);
    end
  endtask

  task automatic check_reg(input string name, input logic [REG_DW-1:0] exp,
                           input logic [REG_DW-1:0] act);
    if (act !== exp) begin
      errors++;
      $display("ERROR %s: expected %h, actual %h", name, exp, act);
    end
  endtask

  task automatic check_keep(input string name, input logic [CPU_KW-1:0] exp,
                            input logic [CPU_KW-1:0] act);
    if (act !== exp) begin
      errors++;
      $display("ERROR %s: expected %b, actual %b", name, exp, act);
    end
  endtask

  task automatic check_user(input string name, input logic [ETH_UW-1:0] exp,
                            input logic [ETH_UW-1:0] act);
    if (act !== exp) begin
      errors++;
      $display("ERROR %s: expected %0d, actual %0d", name, exp, act);
    end
  endtask

  task automatic check_flag(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      errors++;
      $display("ERROR %s: expected %b, actual %b", name, exp, act);
    end
  endtask

  task automatic timeout_abort(input string what);
    $display("Timeout in %s: %s", test_name, what);
    $display("Test summary: %0d errors before the timeout", errors);
    $display("Simulation failed");
    $finish;
  endtask

  ////////////////////
  // Output monitors, sampled at the falling edge

  always @(negedge bus_clk) begin
    if (rst_n && e2v_tvalid && e2v_tready) begin
      if (exp_v_data.size() == 0) begin
        errors++;
        $display("Unexpected beat on e2v during %s", test_name);
      end else begin
        check_beat({test_name, " e2v tdata"}, exp_v_data.pop_front(), e2v_tdata);
        check_flag({test_name, " e2v tlast"}, exp_v_last.pop_front(), e2v_tlast);
      end
    end
  end

  always @(negedge bus_clk) begin
    if (rst_n && e2c_tvalid && e2c_tready) begin
      if (exp_c_data.size() == 0) begin
        errors++;
        $display("Unexpected beat on e2c during %s", test_name);
      end else begin
        check_beat({test_name, " e2c tdata"}, exp_c_data.pop_front(), e2c_tdata);
        check_keep({test_name, " e2c tkeep"}, exp_c_keep.pop_front(), e2c_tkeep);
        check_flag({test_name, " e2c tlast"}, exp_c_last.pop_front(), e2c_tlast);
      end
    end
  end

  always @(negedge bus_clk) begin
    if (rst_n && eth_tx_tvalid && eth_tx_tready) begin
      if (exp_t_data.size() == 0) begin
        errors++;
        $display("Unexpected beat on eth_tx during %s", test_name);
      end else begin
        check_beat({test_name, " eth_tx tdata"}, exp_t_data.pop_front(), eth_tx_tdata);
        check_user({test_name, " eth_tx tuser"}, exp_t_user.pop_front(), eth_tx_tuser);
        check_flag({test_name, " eth_tx tlast"}, exp_t_last.pop_front(), eth_tx_tlast);
      end
    end
  end

  ////////////////////
  // Register port

  task automatic reg_write(input logic [REG_AW-1:0] addr, input logic [REG_DW-1:0] data);
    @(posedge bus_clk);
    reg_wr_req  <= 1'b1;
    reg_wr_addr <= addr;
    reg_wr_data <= data;
    @(posedge bus_clk);
    reg_wr_req <= 1'b0;
  endtask

  task automatic reg_read(input logic [REG_AW-1:0] addr, output logic [REG_DW-1:0] data);
    int n;
    @(posedge bus_clk);
    reg_rd_req  <= 1'b1;
    reg_rd_addr <= addr;
    @(negedge bus_clk);
    if (reg_rd_resp) begin
      errors++;
      $display("Read response for address %h came in the request cycle", addr);
    end
    @(posedge bus_clk);
    reg_rd_req <= 1'b0;
    n = 0;
    do begin
      @(negedge bus_clk);
      n++;
    end while (!reg_rd_resp && n < TIMEOUT);
    if (!reg_rd_resp) timeout_abort("no register read response");
    if (n != 1) begin
      errors++;
      $display("Read response for address %h came %0d cycles after the request", addr, n);
    end
    data = reg_rd_data;
  endtask

  task automatic read_check(input string name, input logic [REG_AW-1:0] addr,
                            input logic [REG_DW-1:0] exp);
    logic [REG_DW-1:0] d;
    reg_read(addr, d);
    check_reg(name, exp, d);
  endtask

  ////////////////////
  // Stream sources

  function automatic logic ready_of(input int src);
    case (src)
      0:       return eth_rx_tready;
      1:       return v2e_tready;
      default: return c2e_tready;
    endcase
  endfunction

  task automatic wait_ready(input int src, input string what);
    int n;
    n = 0;
    do begin
      @(negedge bus_clk);
      n++;
    end while (!ready_of(src) && n < TIMEOUT);
    if (!ready_of(src)) timeout_abort(what);
  endtask

  task automatic add_frame(ref eth_beat_u q[$], ref logic lq[$], input int len,
                           input logic [15:0] etype);
    eth_beat_u b;
    for (int i = 0; i < len; i++) begin
      b = rand64();
      if (i == 0) b.hdr.ethertype = etype;
      q.push_back(b);
      lq.push_back(i == len - 1);
    end
  endtask

  task automatic send_rx(input eth_beat_u q[$], input logic lq[$], input logic [ETH_UW-1:0] user);
    @(posedge bus_clk);
    foreach (q[i]) begin
      eth_rx_tdata  <= q[i];
      eth_rx_tuser  <= lq[i] ? user : '0;
      eth_rx_tlast  <= lq[i];
      eth_rx_tvalid <= 1'b1;
      wait_ready(0, "eth_rx tready stuck low");
      @(posedge bus_clk);
    end
    eth_rx_tvalid <= 1'b0;
  endtask

  task automatic send_v2e(input eth_beat_u q[$], input logic lq[$]);
    @(posedge bus_clk);
    foreach (q[i]) begin
      v2e_tdata  <= q[i];
      v2e_tlast  <= lq[i];
      v2e_tvalid <= 1'b1;
      wait_ready(1, "v2e tready stuck low");
      @(posedge bus_clk);
    end
    v2e_tvalid <= 1'b0;
  endtask

  task automatic send_c2e(input eth_beat_u q[$], input logic lq[$], input logic [CPU_KW-1:0] keep);
    @(posedge bus_clk);
    foreach (q[i]) begin
      c2e_tdata  <= q[i];
      c2e_tkeep  <= lq[i] ? keep : '1;
      c2e_tlast  <= lq[i];
      c2e_tvalid <= 1'b1;
      wait_ready(2, "c2e tready stuck low");
      @(posedge bus_clk);
    end
    c2e_tvalid <= 1'b0;
  endtask

  task automatic expect_e2c(input eth_beat_u q[$], input logic lq[$], input logic [ETH_UW-1:0] user);
    foreach (q[i]) begin
      exp_c_data.push_back(swap_ref(q[i]));
      exp_c_keep.push_back(keep_ref(lq[i], user));
      exp_c_last.push_back(lq[i]);
    end
  endtask

  task automatic wait_drain();
    int n;
    n = 0;
    while ((exp_v_data.size() + exp_c_data.size() + exp_t_data.size()) != 0 && n < TIMEOUT) begin
      @(negedge bus_clk);
      n++;
    end
    if ((exp_v_data.size() + exp_c_data.size() + exp_t_data.size()) != 0)
      timeout_abort("expected output beats never arrived");
  endtask

  ////////////////////
  // Directed tests

  task automatic test_regs();
    test_name = "regs";
    @(negedge bus_clk);
    check_flag("regs e2v_tvalid after reset", 1'b0, e2v_tvalid);
    check_flag("regs e2c_tvalid after reset", 1'b0, e2c_tvalid);
    check_flag("regs eth_tx_tvalid after reset", 1'b0, eth_tx_tvalid);
    check_flag("regs reg_rd_resp after reset", 1'b0, reg_rd_resp);
    check_flag("regs activity_led after reset", 1'b0, activity_led);
    read_check("regs ctrl reset", REG_CTRL, 32'h0000_0001);
    read_check("regs vita type reset", REG_VITA_TYPE, 32'h0000_88B5);
    read_check("regs rx cpu count reset", REG_RX_CPU_CNT, 32'h0);
    read_check("regs rx vita count reset", REG_RX_VITA_CNT, 32'h0);
    read_check("regs tx count reset", REG_TX_CNT, 32'h0);
    read_check("regs unmapped", 14'h14, 32'h0);
    // Upper bits are dropped by the 16-bit type and 1-bit control fields
    reg_write(REG_VITA_TYPE, 32'hFFFF_ABCD);
    read_check("regs vita type write", REG_VITA_TYPE, 32'h0000_ABCD);
    reg_write(REG_CTRL, 32'hFFFF_FFFE);
    read_check("regs ctrl write", REG_CTRL, 32'h0);
    reg_write(REG_CTRL, 32'h1);
    reg_write(REG_VITA_TYPE, 32'h88B5);
    read_check("regs ctrl restore", REG_CTRL, 32'h1);
    read_check("regs vita type restore", REG_VITA_TYPE, 32'h0000_88B5);
  endtask

  task automatic test_route_vita();
    eth_beat_u q[$];
    logic      lq[$];
    test_name = "route_vita";
    stall_en <= 1'b1;
    add_frame(q, lq, 3, 16'h88B5);
    add_frame(q, lq, 1, 16'h88B5);
    add_frame(q, lq, 4, 16'h88B5);
    foreach (q[i]) begin
      exp_v_data.push_back(q[i]);
      exp_v_last.push_back(lq[i]);
    end
    send_rx(q, lq, '0);
    wait_drain();
    n_rx_vita = n_rx_vita + 3;
  endtask

  task automatic test_route_cpu();
    eth_beat_u q[$];
    logic      lq[$];
    test_name = "route_cpu";
    for (int u = 0; u < 8; u++) begin
      q.delete();
      lq.delete();
      add_frame(q, lq, 2, 16'h0800);
      expect_e2c(q, lq, ETH_UW'(u));
      send_rx(q, lq, ETH_UW'(u));
      n_rx_cpu++;
    end
    wait_drain();
    // VITA type with routing off goes to the CPU
    reg_write(REG_CTRL, 32'h0);
    q.delete();
    lq.delete();
    add_frame(q, lq, 3, 16'h88B5);
    add_frame(q, lq, 2, 16'h88B5);
    expect_e2c(q, lq, 4'd3);
    send_rx(q, lq, 4'd3);
    wait_drain();
    n_rx_cpu = n_rx_cpu + 2;
    reg_write(REG_CTRL, 32'h1);
  endtask

  task automatic test_cpu_tx();
    eth_beat_u         q[$];
    logic              lq[$];
    logic [CPU_KW-1:0] keeps[9] = '{8'h01, 8'h03, 8'h07, 8'h0F, 8'h1F, 8'h3F,
                                    8'h7F, 8'hFF, 8'h0B};
    test_name = "cpu_tx";
    foreach (keeps[k]) begin
      q.delete();
      lq.delete();
      add_frame(q, lq, 2, 16'h0800);
      foreach (q[i]) begin
        exp_t_data.push_back(swap_ref(q[i]));
        exp_t_user.push_back(user_ref(lq[i], keeps[k]));
        exp_t_last.push_back(lq[i]);
      end
      send_c2e(q, lq, keeps[k]);
      n_tx++;
    end
    wait_drain();
  endtask

  task automatic test_tx_merge();
    eth_beat_u vq[$];
    eth_beat_u cq[$];
    logic      vl[$];
    logic      cl[$];
    test_name = "tx_merge";
    for (int f = 0; f < 3; f++) begin
      add_frame(vq, vl, 3, 16'h88B5);
      add_frame(cq, cl, 2, 16'h0800);
    end
    // Both sources start on the same edge, so frames alternate from VITA
    for (int f = 0; f < 3; f++) begin
      for (int i = 0; i < 3; i++) begin
        exp_t_data.push_back(vq[3*f+i]);
        exp_t_user.push_back('0);
        exp_t_last.push_back(vl[3*f+i]);
      end
      for (int i = 0; i < 2; i++) begin
        exp_t_data.push_back(swap_ref(cq[2*f+i]));
        exp_t_user.push_back(user_ref(cl[2*f+i], 8'h0F));
        exp_t_last.push_back(cl[2*f+i]);
      end
    end
    fork
      send_v2e(vq, vl);
      send_c2e(cq, cl, 8'h0F);
    join
    wait_drain();
    n_tx = n_tx + 6;
  endtask

  task automatic test_counters_led();
    eth_beat_u q[$];
    logic      lq[$];
    test_name = "counters_led";
    stall_en <= 1'b0;
    repeat (ACT_STRETCH + 2) @(posedge bus_clk);
    @(negedge bus_clk);
    check_flag("counters_led led idle", 1'b0, activity_led);
    add_frame(q, lq, 1, 16'h0800);
    expect_e2c(q, lq, '0);
    send_rx(q, lq, '0);
    n_rx_cpu++;
    // send_rx returns on the edge that took the beat
    @(negedge bus_clk);
    check_flag("counters_led led after beat", 1'b1, activity_led);
    repeat (ACT_STRETCH - 2) @(negedge bus_clk);
    check_flag("counters_led led near end", 1'b1, activity_led);
    @(negedge bus_clk);
    check_flag("counters_led led after stretch", 1'b0, activity_led);
    wait_drain();
    read_check("counters_led rx cpu count", REG_RX_CPU_CNT, REG_DW'(n_rx_cpu));
    read_check("counters_led rx vita count", REG_RX_VITA_CNT, REG_DW'(n_rx_vita));
    read_check("counters_led tx count", REG_TX_CNT, REG_DW'(n_tx));
    reg_write(REG_TX_CNT, 32'h0);
    read_check("counters_led tx count cleared", REG_TX_CNT, 32'h0);
    read_check("counters_led rx cpu count kept", REG_RX_CPU_CNT, REG_DW'(n_rx_cpu));
  endtask

  initial begin
    rst_n         = 1'b0;
    reg_wr_req    = 1'b0;
    reg_wr_addr   = '0;
    reg_wr_data   = '0;
    reg_rd_req    = 1'b0;
    reg_rd_addr   = '0;
    eth_rx_tdata  = '0;
    eth_rx_tuser  = '0;
    eth_rx_tlast  = 1'b0;
    eth_rx_tvalid = 1'b0;
    eth_tx_tready = 1'b1;
    e2v_tready    = 1'b1;
    v2e_tdata     = '0;
    v2e_tlast     = 1'b0;
    v2e_tvalid    = 1'b0;
    e2c_tready    = 1'b1;
    c2e_tdata     = '0;
    c2e_tkeep     = '1;
    c2e_tlast     = 1'b0;
    c2e_tvalid    = 1'b0;
    repeat (2) @(posedge bus_clk);
    rst_n <= 1'b1;
    test_regs();
    test_route_vita();
    test_route_cpu();
    test_cpu_tx();
    test_tx_merge();
    test_counters_led();
    $display("Test summary: %0d errors", errors);
    if (errors == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== net_if.f ====
verilog/eth_stream_pkg.sv
verilog/net_regs_pkg.sv
verilog/axis_if.sv
verilog/net_ctrl.sv
verilog/eth_rx_router.sv
verilog/eth_tx_arbiter.sv
verilog/cpu_stream_adapter.sv
verilog/net_if_top.sv
tests/net_if_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Builds the network port testbench with Verilator and runs it.
# Exits nonzero if the build or the run fails, or if the log reports failure.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
  --top-module net_if_tb -f net_if.f --Mdir obj_dir -o net_if_sim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/net_if_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "Simulator exited with status $status"
  exit 1
fi

if grep -q "Simulation failed" sim.log; then
  exit 1
fi
exit 0
